// File: logic/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// sizes pc and the predicted target
`define DEC_ADDR_W 32

// arch register fields are zero padded to this
`define DEC_PREG_W 6

`define DEC_PHT_W 10

// jal / bgezal link target
`define DEC_LINK_REG 31

`endif

// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

	// primary opcode field insn[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'd0, OP_REGIMM = 6'd1, OP_J = 6'd2, OP_JAL = 6'd3,
		OP_BEQ = 6'd4, OP_BNE = 6'd5, OP_BLEZ = 6'd6, OP_BGTZ = 6'd7,
		OP_ADDIU = 6'd9, OP_SLTI = 6'd10, OP_SLTIU = 6'd11, OP_ANDI = 6'd12,
		OP_ORI = 6'd13, OP_XORI = 6'd14, OP_LUI = 6'd15,
		OP_BEQL = 6'd20, OP_BNEL = 6'd21, OP_BLEZL = 6'd22, OP_BGTZL = 6'd23,
		OP_LB = 6'd32, OP_LH = 6'd33, OP_LWL = 6'd34, OP_LW = 6'd35,
		OP_LBU = 6'd36, OP_LHU = 6'd37, OP_LWR = 6'd38,
		OP_SB = 6'd40, OP_SH = 6'd41, OP_SWL = 6'd42, OP_SW = 6'd43,
		OP_SWR = 6'd46, OP_LL = 6'd48, OP_PREF = 6'd51
	} major_op_t;

	// SPECIAL function field insn[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'd0, FN_SRL = 6'd2, FN_SRA = 6'd3, FN_SLLV = 6'd4,
		FN_SRLV = 6'd6, FN_SRAV = 6'd7, FN_JR = 6'd8, FN_JALR = 6'd9,
		FN_SYNC = 6'd15, FN_MFHI = 6'd16, FN_MTHI = 6'd17, FN_MFLO = 6'd18,
		FN_MTLO = 6'd19, FN_MULT = 6'd24, FN_MULTU = 6'd25, FN_DIV = 6'd26,
		FN_DIVU = 6'd27, FN_ADDU = 6'd33, FN_SUBU = 6'd35, FN_AND = 6'd36,
		FN_OR = 6'd37, FN_XOR = 6'd38, FN_NOR = 6'd39, FN_SLT = 6'd42,
		FN_SLTU = 6'd43, FN_TEQ = 6'd52
	} funct_t;

	// REGIMM rt field insn[20:16]
	typedef enum logic [4:0] {
		RI_BLTZ = 5'd0, RI_BGEZ = 5'd1, RI_BLTZL = 5'd2, RI_BGEZL = 5'd3,
		RI_BGEZAL = 5'd17
	} regimm_t;

	// internal micro-op with II kept at zero
	typedef enum logic [5:0] {
		II, NOP, SLL, SRL, SRA, SLLV, SRLV, SRAV,
		JR, JALR, MFHI, MTHI, MFLO, MTLO, MULT, MULTU,
		DIV, DIVU, ADDU, SUBU, AND, OR, XOR, NOR,
		SLT, SLTU, MOV, ADDIU, MOVI, SLTI, SLTIU, ANDI,
		ORI, XORI, LUI, BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL,
		BAL, J, JAL, BEQ, BNE, BLEZ, BGTZ, BEQL,
		BNEL, BLEZL, BGTZL, LB, LH, LWL, LW, LBU,
		LHU, LWR, SB, SH, SWL, SW, SWR
	} uop_op_t;

endpackage

`default_nettype wire

// File: logic/decode_rtype.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_rtype (
	input wire [31:0] insn,
	input wire [`DEC_ADDR_W-1:0] insn_pred_target,
	output logic hit,
	output decode_pkg::uop_op_t op,
	output logic [`DEC_PREG_W-1:0] src_a,
	output logic src_a_valid,
	output logic [`DEC_PREG_W-1:0] src_b,
	output logic src_b_valid,
	output logic [`DEC_PREG_W-1:0] dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic is_int,
	output logic has_delay_slot,
	output logic is_br,
	output logic hilo_src_valid,
	output logic hilo_dst_valid,
	output logic [`DEC_ADDR_W-17:0] jmp_imm
);
	import decode_pkg::*;

	localparam int zp = `DEC_PREG_W - 5;

	major_op_t opcode;
	funct_t funct;
	logic [`DEC_PREG_W-1:0] rs;
	logic [`DEC_PREG_W-1:0] rt;
	logic [`DEC_PREG_W-1:0] rd;
	logic [`DEC_PREG_W-1:0] shamt;
	logic rd_wr; // result goes to rd

	assign opcode = major_op_t'(insn[31:26]);
	assign funct = funct_t'(insn[5:0]);
	assign rs = {{zp{1'b0}}, insn[25:21]};
	assign rt = {{zp{1'b0}}, insn[20:16]};
	assign rd = {{zp{1'b0}}, insn[15:11]};
	assign shamt = {{zp{1'b0}}, insn[10:6]};

	always_comb
	begin
		op = II;
		{hit, src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm} = '0;
		{has_delay_slot, is_br, hilo_src_valid, hilo_dst_valid, jmp_imm} = '0;
		rd_wr = 1'b0;
		if (opcode == OP_SPECIAL)
		begin
			hit = 1'b1;
			case (funct)
				FN_SLL: op = SLL;
				FN_SRL: op = SRL;
				FN_SRA: op = SRA;
				FN_SLLV: op = SLLV;
				FN_SRLV: op = SRLV;
				FN_SRAV: op = SRAV;
				FN_JR: op = JR;
				FN_JALR: op = JALR;
				FN_MFHI: op = MFHI;
				FN_MTHI: op = MTHI;
				FN_MFLO: op = MFLO;
				FN_MTLO: op = MTLO;
				FN_MULT: op = MULT;
				FN_MULTU: op = MULTU;
				FN_DIV: op = DIV;
				FN_DIVU: op = DIVU;
				FN_ADDU: op = ADDU;
				FN_SUBU: op = SUBU;
				FN_AND: op = AND;
				FN_OR: op = (rs == '0) ? MOV : OR;
				FN_XOR: op = XOR;
				FN_NOR: op = NOR;
				FN_SLT: op = SLT;
				FN_SLTU: op = SLTU;
				FN_SYNC, FN_TEQ: op = NOP; // no side effects in this core
				default: hit = 1'b0;
			endcase
			case (funct)
				FN_SLL, FN_SRL, FN_SRA:
				begin
					src_a = rt;
					src_a_valid = 1'b1;
					src_b = shamt; // shift amount, not a register
					rd_wr = 1'b1;
				end
				FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_AND, FN_OR,
				FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
				begin
					src_a = rt;
					src_a_valid = 1'b1;
					src_b = rs;
					src_b_valid = 1'b1;
					rd_wr = 1'b1;
				end
				FN_SUBU, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:
				begin
					src_a = rs;
					src_a_valid = 1'b1;
					src_b = rt;
					src_b_valid = 1'b1;
					rd_wr = (funct == FN_SUBU);
					hilo_dst_valid = (funct != FN_SUBU);
				end
				FN_JR, FN_JALR:
				begin
					src_a = rs;
					src_a_valid = 1'b1;
					has_delay_slot = 1'b1;
					is_br = 1'b1;
					imm = insn_pred_target[15:0];
					jmp_imm = insn_pred_target[`DEC_ADDR_W-1:16];
					dst = (funct == FN_JALR) ? rd : '0;
					dst_valid = (funct == FN_JALR) && (rd != '0);
				end
				FN_MFHI, FN_MFLO:
				begin
					hilo_src_valid = 1'b1;
					rd_wr = 1'b1;
				end
				FN_MTHI, FN_MTLO:
				begin
					src_a = rs;
					src_a_valid = 1'b1;
					hilo_src_valid = 1'b1; // other half is preserved
					hilo_dst_valid = 1'b1;
				end
			endcase
		end
		is_int = hit;
		if (op == MOV)
		begin
			src_b = '0;
			src_b_valid = 1'b0;
		end
		// folding r0 writes also covers the zero word and ehb
		if (rd_wr)
		begin
			dst = rd;
			dst_valid = (rd != '0);
			if (rd == '0)
				op = NOP;
		end
	end

endmodule

`default_nettype wire

// File: logic/decode_imm_alu.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_imm_alu (
	input wire [31:0] insn,
	output logic hit,
	output decode_pkg::uop_op_t op,
	output logic [`DEC_PREG_W-1:0] src_a,
	output logic src_a_valid,
	output logic [`DEC_PREG_W-1:0] src_b,
	output logic src_b_valid,
	output logic [`DEC_PREG_W-1:0] dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic is_int
);
	import decode_pkg::*;

	localparam int zp = `DEC_PREG_W - 5;

	major_op_t opcode;
	logic [`DEC_PREG_W-1:0] rs;
	logic [`DEC_PREG_W-1:0] rt;

	assign opcode = major_op_t'(insn[31:26]);
	assign rs = {{zp{1'b0}}, insn[25:21]};
	assign rt = {{zp{1'b0}}, insn[20:16]};

	always_comb
	begin
		op = II;
		{src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm, is_int} = '0;
		case (opcode)
			OP_ADDIU: op = (rs == '0) ? MOVI : ADDIU; // li idiom
			OP_SLTI: op = SLTI;
			OP_SLTIU: op = SLTIU;
			OP_ANDI: op = ANDI;
			OP_ORI: op = ORI;
			OP_XORI: op = XORI;
			OP_LUI: op = LUI;
			default: op = II;
		endcase
		hit = (op != II);
		if (hit)
		begin
			is_int = 1'b1;
			imm = insn[15:0];
			src_a_valid = (op != MOVI) && (op != LUI);
			src_a = src_a_valid ? rs : '0;
			dst = rt;
			dst_valid = (rt != '0);
			if (rt == '0)
				op = NOP;
		end
	end

endmodule

`default_nettype wire

// File: logic/decode_branch.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_branch (
	input wire [31:0] insn,
	input wire insn_pred,
	output logic hit,
	output decode_pkg::uop_op_t op,
	output logic [`DEC_PREG_W-1:0] src_a,
	output logic src_a_valid,
	output logic [`DEC_PREG_W-1:0] src_b,
	output logic src_b_valid,
	output logic [`DEC_PREG_W-1:0] dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic is_int,
	output logic br_pred,
	output logic is_br,
	output logic has_delay_slot,
	output logic has_nullifying_delay_slot,
	output logic [`DEC_ADDR_W-17:0] jmp_imm
);
	import decode_pkg::*;

	localparam int zp = `DEC_PREG_W - 5;
	localparam logic [`DEC_PREG_W-1:0] link_reg = `DEC_PREG_W'(`DEC_LINK_REG);

	major_op_t opcode;
	regimm_t rimm;
	logic [`DEC_PREG_W-1:0] rs;
	logic [`DEC_PREG_W-1:0] rt;
	logic cond_br; // pc relative and predicted

	assign opcode = major_op_t'(insn[31:26]);
	assign rimm = regimm_t'(insn[20:16]);
	assign rs = {{zp{1'b0}}, insn[25:21]};
	assign rt = {{zp{1'b0}}, insn[20:16]};
	assign cond_br = opcode inside {OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};

	always_comb
	begin
		op = II;
		{src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm, br_pred} = '0;
		jmp_imm = '0;
		hit = cond_br || (opcode inside {OP_J, OP_JAL});
		is_br = hit;
		is_int = hit;
		has_delay_slot = hit;
		has_nullifying_delay_slot = opcode inside {OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL};
		if (cond_br)
		begin
			src_a = rs;
			src_a_valid = 1'b1;
			imm = insn[15:0];
			br_pred = insn_pred;
		end
		if (opcode inside {OP_BEQ, OP_BNE, OP_BEQL, OP_BNEL})
		begin
			src_b = rt;
			src_b_valid = 1'b1;
		end
		case (opcode)
			OP_REGIMM:
			begin
				case (rimm)
					RI_BLTZ: op = BLTZ;
					RI_BGEZ: op = BGEZ;
					RI_BLTZL: op = BLTZL;
					RI_BGEZL: op = BGEZL;
					RI_BGEZAL:
					begin
						op = (rs == '0) ? BAL : BGEZAL; // bgezal r0 always taken
						dst = link_reg;
						dst_valid = 1'b1;
						src_b = link_reg;
						src_b_valid = (rs != '0);
					end
					default: op = II;
				endcase
				has_nullifying_delay_slot = rimm inside {RI_BLTZL, RI_BGEZL};
			end
			OP_BEQ: op = BEQ;
			OP_BNE: op = BNE;
			OP_BLEZ: op = BLEZ;
			OP_BGTZ: op = BGTZ;
			OP_BEQL: op = BEQL;
			OP_BNEL: op = BNEL;
			OP_BLEZL: op = BLEZL;
			OP_BGTZL: op = BGTZL;
			OP_J: op = J;
			OP_JAL:
			begin
				op = JAL;
				imm = insn[15:0];
				jmp_imm = {{(`DEC_ADDR_W-26){1'b0}}, insn[25:16]};
				dst = link_reg;
				dst_valid = 1'b1;
				br_pred = 1'b1;
			end
			default: op = II;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/decode_mem.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_mem (
	input wire [31:0] insn,
	output logic hit,
	output decode_pkg::uop_op_t op,
	output logic [`DEC_PREG_W-1:0] src_a,
	output logic src_a_valid,
	output logic [`DEC_PREG_W-1:0] src_b,
	output logic src_b_valid,
	output logic [`DEC_PREG_W-1:0] dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic is_int,
	output logic is_mem,
	output logic is_store
);
	import decode_pkg::*;

	localparam int zp = `DEC_PREG_W - 5;

	major_op_t opcode;
	logic [`DEC_PREG_W-1:0] rs;
	logic [`DEC_PREG_W-1:0] rt;

	assign opcode = major_op_t'(insn[31:26]);
	assign rs = {{zp{1'b0}}, insn[25:21]};
	assign rt = {{zp{1'b0}}, insn[20:16]};

	always_comb
	begin
		op = II;
		{src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm} = '0;
		case (opcode)
			OP_LB: op = LB;
			OP_LH: op = LH;
			OP_LWL: op = LWL;
			OP_LW, OP_LL: op = LW; // no reservation tracking
			OP_LBU: op = LBU;
			OP_LHU: op = LHU;
			OP_LWR: op = LWR;
			OP_SB: op = SB;
			OP_SH: op = SH;
			OP_SWL: op = SWL;
			OP_SW: op = SW;
			OP_SWR: op = SWR;
			OP_PREF: op = NOP;
			default: op = II;
		endcase
		hit = (op != II);
		is_int = (opcode == OP_PREF);
		is_mem = hit && !is_int;
		is_store = opcode inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};
		if (is_mem)
		begin
			src_a = rs;
			src_a_valid = 1'b1;
			imm = insn[15:0];
		end
		// unaligned loads merge into the old rt value
		if (is_store || (opcode inside {OP_LWL, OP_LWR}))
		begin
			src_b = rt;
			src_b_valid = 1'b1;
		end
		if (is_mem && !is_store)
		begin
			dst = rt;
			dst_valid = (rt != '0);
		end
	end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire insn_valid,
	input wire [31:0] insn,
	input wire [`DEC_ADDR_W-1:0] pc,
	input wire insn_pred,
	input wire [`DEC_PHT_W-1:0] pht_idx,
	input wire [`DEC_ADDR_W-1:0] insn_pred_target,
	output logic uop_valid,
	output decode_pkg::uop_op_t uop_op,
	output logic [`DEC_PREG_W-1:0] src_a,
	output logic src_a_valid,
	output logic [`DEC_PREG_W-1:0] src_b,
	output logic src_b_valid,
	output logic [`DEC_PREG_W-1:0] dst,
	output logic dst_valid,
	output logic [15:0] imm,
	output logic [`DEC_ADDR_W-17:0] jmp_imm,
	output logic [`DEC_ADDR_W-1:0] uop_pc,
	output logic [`DEC_PHT_W-1:0] uop_pht_idx,
	output logic br_pred,
	output logic is_br,
	output logic has_delay_slot,
	output logic has_nullifying_delay_slot,
	output logic is_mem,
	output logic is_store,
	output logic is_int,
	output logic hilo_src_valid,
	output logic hilo_dst_valid
);
	import decode_pkg::*;

	logic [3:0] hits; // special, imm alu, branch, mem
	uop_op_t d_op [4];
	logic [`DEC_PREG_W-1:0] d_src_a [4];
	logic d_src_a_valid [4];
	logic [`DEC_PREG_W-1:0] d_src_b [4];
	logic d_src_b_valid [4];
	logic [`DEC_PREG_W-1:0] d_dst [4];
	logic d_dst_valid [4];
	logic [15:0] d_imm [4];
	logic d_is_int [4];
	logic sp_has_delay_slot;
	logic sp_is_br;
	logic sp_hilo_src_valid;
	logic sp_hilo_dst_valid;
	logic [`DEC_ADDR_W-17:0] sp_jmp_imm;
	logic bc_br_pred;
	logic bc_is_br;
	logic bc_has_delay_slot;
	logic bc_has_nullifying_delay_slot;
	logic [`DEC_ADDR_W-17:0] bc_jmp_imm;
	logic mc_is_mem;
	logic mc_is_store;

	decode_rtype decode_rtype_inst (
		.insn(insn), .insn_pred_target(insn_pred_target), .hit(hits[0]), .op(d_op[0]),
		.src_a(d_src_a[0]), .src_a_valid(d_src_a_valid[0]),
		.src_b(d_src_b[0]), .src_b_valid(d_src_b_valid[0]),
		.dst(d_dst[0]), .dst_valid(d_dst_valid[0]), .imm(d_imm[0]), .is_int(d_is_int[0]),
		.has_delay_slot(sp_has_delay_slot), .is_br(sp_is_br), .jmp_imm(sp_jmp_imm),
		.hilo_src_valid(sp_hilo_src_valid), .hilo_dst_valid(sp_hilo_dst_valid)
	);

	decode_imm_alu decode_imm_alu_inst (
		.insn(insn), .hit(hits[1]), .op(d_op[1]),
		.src_a(d_src_a[1]), .src_a_valid(d_src_a_valid[1]),
		.src_b(d_src_b[1]), .src_b_valid(d_src_b_valid[1]),
		.dst(d_dst[1]), .dst_valid(d_dst_valid[1]), .imm(d_imm[1]), .is_int(d_is_int[1])
	);

	decode_branch decode_branch_inst (
		.insn(insn), .insn_pred(insn_pred), .hit(hits[2]), .op(d_op[2]),
		.src_a(d_src_a[2]), .src_a_valid(d_src_a_valid[2]),
		.src_b(d_src_b[2]), .src_b_valid(d_src_b_valid[2]),
		.dst(d_dst[2]), .dst_valid(d_dst_valid[2]), .imm(d_imm[2]), .is_int(d_is_int[2]),
		.br_pred(bc_br_pred), .is_br(bc_is_br), .has_delay_slot(bc_has_delay_slot),
		.has_nullifying_delay_slot(bc_has_nullifying_delay_slot), .jmp_imm(bc_jmp_imm)
	);

	decode_mem decode_mem_inst (
		.insn(insn), .hit(hits[3]), .op(d_op[3]),
		.src_a(d_src_a[3]), .src_a_valid(d_src_a_valid[3]),
		.src_b(d_src_b[3]), .src_b_valid(d_src_b_valid[3]),
		.dst(d_dst[3]), .dst_valid(d_dst_valid[3]), .imm(d_imm[3]), .is_int(d_is_int[3]),
		.is_mem(mc_is_mem), .is_store(mc_is_store)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			uop_valid <= 1'b0;
			uop_op <= II;
			{src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm, is_int} <= '0;
			{jmp_imm, uop_pc, uop_pht_idx} <= '0;
			{br_pred, is_br, has_delay_slot, has_nullifying_delay_slot} <= '0;
			{is_mem, is_store, hilo_src_valid, hilo_dst_valid} <= '0;
		end
		else
		begin
			uop_valid <= insn_valid;
			if (insn_valid)
			begin
				uop_op <= II; // no class claimed it
				{src_a, src_a_valid, src_b, src_b_valid, dst, dst_valid, imm, is_int} <= '0;
				for (int i = 0; i < 4; i++)
				begin
					if (hits[i])
					begin
						uop_op <= d_op[i];
						{src_a, src_a_valid, src_b, src_b_valid} <=
							{d_src_a[i], d_src_a_valid[i], d_src_b[i], d_src_b_valid[i]};
						{dst, dst_valid, imm, is_int} <=
							{d_dst[i], d_dst_valid[i], d_imm[i], d_is_int[i]};
					end
				end
				jmp_imm <= hits[0] ? sp_jmp_imm : (hits[2] ? bc_jmp_imm : '0);
				uop_pc <= pc;
				uop_pht_idx <= pht_idx;
				br_pred <= hits[2] & bc_br_pred;
				is_br <= (hits[0] & sp_is_br) | (hits[2] & bc_is_br);
				has_delay_slot <= (hits[0] & sp_has_delay_slot) | (hits[2] & bc_has_delay_slot);
				has_nullifying_delay_slot <= hits[2] & bc_has_nullifying_delay_slot;
				is_mem <= hits[3] & mc_is_mem;
				is_store <= hits[3] & mc_is_store;
				hilo_src_valid <= hits[0] & sp_hilo_src_valid;
				hilo_dst_valid <= hits[0] & sp_hilo_dst_valid;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/decode_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module decode_clock_gen (
	output logic clk,
	output logic rst_n
);
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/decode_properties.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_properties (
	input wire clk,
	input wire rst_n,
	input wire insn_valid,
	input wire uop_valid,
	input wire is_mem,
	input wire is_store,
	input wire has_delay_slot,
	input wire has_nullifying_delay_slot,
	input wire dst_valid,
	input wire [`DEC_PREG_W-1:0] dst,
	input wire [3:0] hits
);
	int assert_errors = 0;

	valid_follows_input: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (uop_valid == $past(insn_valid)))
	else
	begin
		assert_errors++;
		$error("uop_valid does not match insn_valid of the previous cycle");
	end

	store_is_mem: assert property (@(posedge clk) disable iff (!rst_n) is_store |-> is_mem)
	else
	begin
		assert_errors++;
		$error("is_store set without is_mem");
	end

	nullify_has_slot: assert property (@(posedge clk) disable iff (!rst_n)
		has_nullifying_delay_slot |-> has_delay_slot)
	else
	begin
		assert_errors++;
		$error("nullifying delay slot without a delay slot");
	end

	dst_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		dst_valid |-> (dst != '0))
	else
	begin
		assert_errors++;
		$error("dst_valid set for register zero");
	end

	one_class_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hits))
	else
	begin
		assert_errors++;
		$error("more than one class decoder hit");
	end

endmodule

bind decode_stage decode_properties decode_properties_inst (
	.clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .uop_valid(uop_valid),
	.is_mem(is_mem), .is_store(is_store), .has_delay_slot(has_delay_slot),
	.has_nullifying_delay_slot(has_nullifying_delay_slot), .dst_valid(dst_valid),
	.dst(dst), .hits(hits)
);

`default_nettype wire

// File: tb/decode_tb.sv
`default_nettype none
`timescale 1ns/100ps
`include "decode_config.svh"

module decode_tb;
	import decode_pkg::*;

	localparam int wait_limit = 8;
	// expected flag bits
	localparam logic [8:0] fl_int = 9'h001;
	localparam logic [8:0] fl_mem = 9'h002;
	localparam logic [8:0] fl_st = 9'h004;
	localparam logic [8:0] fl_br = 9'h008;
	localparam logic [8:0] fl_ds = 9'h010;
	localparam logic [8:0] fl_nds = 9'h020;
	localparam logic [8:0] fl_pred = 9'h040;
	localparam logic [8:0] fl_hs = 9'h080;
	localparam logic [8:0] fl_hd = 9'h100;

	wire clk;
	wire rst_n;
	logic insn_valid;
	logic [31:0] insn;
	logic [`DEC_ADDR_W-1:0] pc;
	logic insn_pred;
	logic [`DEC_PHT_W-1:0] pht_idx;
	logic [`DEC_ADDR_W-1:0] insn_pred_target;
	logic uop_valid;
	uop_op_t uop_op;
	logic [`DEC_PREG_W-1:0] src_a;
	logic src_a_valid;
	logic [`DEC_PREG_W-1:0] src_b;
	logic src_b_valid;
	logic [`DEC_PREG_W-1:0] dst;
	logic dst_valid;
	logic [15:0] imm;
	logic [`DEC_ADDR_W-17:0] jmp_imm;
	logic [`DEC_ADDR_W-1:0] uop_pc;
	logic [`DEC_PHT_W-1:0] uop_pht_idx;
	logic br_pred;
	logic is_br;
	logic has_delay_slot;
	logic has_nullifying_delay_slot;
	logic is_mem;
	logic is_store;
	logic is_int;
	logic hilo_src_valid;
	logic hilo_dst_valid;

	uop_op_t e_op;
	logic [`DEC_PREG_W-1:0] e_sa;
	logic e_sav;
	logic [`DEC_PREG_W-1:0] e_sb;
	logic e_sbv;
	logic [`DEC_PREG_W-1:0] e_dst;
	logic e_dv;
	logic [15:0] e_imm;
	logic [`DEC_ADDR_W-17:0] e_jmp;
	logic [8:0] e_flags;
	logic [31:0] rng;
	logic [`DEC_ADDR_W-1:0] next_pc;

	decode_clock_gen decode_clock_gen_inst (.clk(clk), .rst_n(rst_n));

	decode_stage decode_stage_inst (.*);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "decode_tb stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] k);
		return {op, rs, rt, k};
	endfunction

	task automatic expect_uop(input uop_op_t op, input int sa, input logic sav, input int sb,
		input logic sbv, input int d, input logic dv, input logic [15:0] k,
		input logic [8:0] flags);
		e_op = op;
		e_sa = sa;
		e_sav = sav;
		e_sb = sb;
		e_sbv = sbv;
		e_dst = d;
		e_dv = dv;
		e_imm = k;
		e_jmp = '0; // only jumps override this
		e_flags = flags;
	endtask

	task automatic compare_uop(input logic [`DEC_ADDR_W-1:0] p);
		check("uop_op", uop_op, e_op);
		check("src_a", src_a, e_sa);
		check("src_a_valid", src_a_valid, e_sav);
		check("src_b", src_b, e_sb);
		check("src_b_valid", src_b_valid, e_sbv);
		check("dst", dst, e_dst);
		check("dst_valid", dst_valid, e_dv);
		check("imm", imm, e_imm);
		check("jmp_imm", jmp_imm, e_jmp);
		check("uop_pc", uop_pc, p);
		check("uop_pht_idx", uop_pht_idx, p[`DEC_PHT_W+1:2]);
		check("is_int", is_int, e_flags[0]);
		check("is_mem", is_mem, e_flags[1]);
		check("is_store", is_store, e_flags[2]);
		check("is_br", is_br, e_flags[3]);
		check("has_delay_slot", has_delay_slot, e_flags[4]);
		check("has_nullifying_delay_slot", has_nullifying_delay_slot, e_flags[5]);
		check("br_pred", br_pred, e_flags[6]);
		check("hilo_src_valid", hilo_src_valid, e_flags[7]);
		check("hilo_dst_valid", hilo_dst_valid, e_flags[8]);
	endtask

	task automatic expect_addiu(input logic [31:0] w);
		logic [4:0] rs;
		logic [4:0] rt;
		uop_op_t op;
		rs = w[25:21];
		rt = w[20:16];
		if (rt == 0)
			op = NOP;
		else if (rs == 0)
			op = MOVI;
		else
			op = ADDIU;
		expect_uop(op, rs, rs != 0, 0, 1'b0, rt, rt != 0, w[15:0], fl_int);
	endtask

	// drives one instruction and compares its uop with e_*
	task automatic issue(input logic [31:0] w, input logic pred, input logic [31:0] target);
		int n;
		logic [`DEC_ADDR_W-1:0] this_pc;
		this_pc = next_pc;
		next_pc += 4;
		@(posedge clk);
		insn_valid <= 1'b1;
		insn <= w;
		pc <= this_pc;
		insn_pred <= pred;
		pht_idx <= this_pc[`DEC_PHT_W+1:2];
		insn_pred_target <= target;
		@(posedge clk);
		insn_valid <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!uop_valid && n < wait_limit);
		if (!uop_valid)
			abort_run($sformatf("uop_valid never rose for instruction 0x%08h", w));
		compare_uop(this_pc);
	endtask

	task automatic test_reset_state();
		int n;
		n = 0;
		while (!rst_n && n < 20)
		begin
			@(posedge clk);
			n++;
		end
		if (!rst_n)
			abort_run("reset was never released");
		@(negedge clk);
		check("uop_valid", uop_valid, 0);
		expect_uop(II, 0, 1'b0, 0, 1'b0, 0, 1'b0, 16'h0, 9'h0);
		compare_uop('0);
	endtask

	task automatic test_rtype();
		expect_uop(ADDU, 9, 1'b1, 8, 1'b1, 10, 1'b1, 16'h0, fl_int);
		issue(enc_r(8, 9, 10, 0, FN_ADDU), 1'b0, '0);
		expect_uop(SUBU, 8, 1'b1, 9, 1'b1, 10, 1'b1, 16'h0, fl_int);
		issue(enc_r(8, 9, 10, 0, FN_SUBU), 1'b0, '0);
		expect_uop(OR, 9, 1'b1, 8, 1'b1, 10, 1'b1, 16'h0, fl_int);
		issue(enc_r(8, 9, 10, 0, FN_OR), 1'b0, '0);
		expect_uop(MOV, 9, 1'b1, 0, 1'b0, 10, 1'b1, 16'h0, fl_int);
		issue(enc_r(0, 9, 10, 0, FN_OR), 1'b0, '0);
		expect_uop(SLL, 9, 1'b1, 4, 1'b0, 10, 1'b1, 16'h0, fl_int); // shamt in src_b
		issue(enc_r(0, 9, 10, 4, FN_SLL), 1'b0, '0);
		expect_uop(SLLV, 9, 1'b1, 8, 1'b1, 10, 1'b1, 16'h0, fl_int);
		issue(enc_r(8, 9, 10, 0, FN_SLLV), 1'b0, '0);
		expect_uop(NOP, 9, 1'b1, 8, 1'b1, 0, 1'b0, 16'h0, fl_int);
		issue(enc_r(8, 9, 0, 0, FN_ADDU), 1'b0, '0);
		expect_uop(MULT, 8, 1'b1, 9, 1'b1, 0, 1'b0, 16'h0, fl_int | fl_hd);
		issue(enc_r(8, 9, 0, 0, FN_MULT), 1'b0, '0);
		expect_uop(MFHI, 0, 1'b0, 0, 1'b0, 10, 1'b1, 16'h0, fl_int | fl_hs);
		issue(enc_r(0, 0, 10, 0, FN_MFHI), 1'b0, '0);
		expect_uop(NOP, 0, 1'b0, 0, 1'b0, 0, 1'b0, 16'h0, fl_int);
		issue(enc_r(0, 0, 0, 0, FN_SYNC), 1'b0, '0);
		expect_uop(JR, 31, 1'b1, 0, 1'b0, 0, 1'b0, 16'h5678, fl_int | fl_br | fl_ds);
		e_jmp = 16'h1234;
		issue(enc_r(31, 0, 0, 0, FN_JR), 1'b0, 32'h1234_5678);
	endtask

	task automatic test_imm_alu();
		expect_uop(ADDIU, 3, 1'b1, 0, 1'b0, 4, 1'b1, 16'h8001, fl_int);
		issue(enc_i(OP_ADDIU, 3, 4, 16'h8001), 1'b0, '0);
		expect_uop(ORI, 5, 1'b1, 0, 1'b0, 6, 1'b1, 16'h00ff, fl_int);
		issue(enc_i(OP_ORI, 5, 6, 16'h00ff), 1'b0, '0);
		expect_uop(LUI, 0, 1'b0, 0, 1'b0, 7, 1'b1, 16'h1234, fl_int);
		issue(enc_i(OP_LUI, 0, 7, 16'h1234), 1'b0, '0);
		expect_uop(MOVI, 0, 1'b0, 0, 1'b0, 4, 1'b1, 16'h0042, fl_int);
		issue(enc_i(OP_ADDIU, 0, 4, 16'h0042), 1'b0, '0);
		expect_uop(NOP, 3, 1'b1, 0, 1'b0, 0, 1'b0, 16'h0005, fl_int);
		issue(enc_i(OP_SLTI, 3, 0, 16'h0005), 1'b0, '0);
	endtask

	task automatic test_branch();
		expect_uop(BEQ, 1, 1'b1, 2, 1'b1, 0, 1'b0, 16'h0010, fl_int | fl_br | fl_ds | fl_pred);
		issue(enc_i(OP_BEQ, 1, 2, 16'h0010), 1'b1, '0);
		expect_uop(BNE, 1, 1'b1, 2, 1'b1, 0, 1'b0, 16'hfff0, fl_int | fl_br | fl_ds);
		issue(enc_i(OP_BNE, 1, 2, 16'hfff0), 1'b0, '0);
		expect_uop(BEQL, 1, 1'b1, 2, 1'b1, 0, 1'b0, 16'h0010, fl_int | fl_br | fl_ds | fl_nds);
		issue(enc_i(OP_BEQL, 1, 2, 16'h0010), 1'b0, '0);
		expect_uop(BGEZAL, 4, 1'b1, 31, 1'b1, 31, 1'b1, 16'h0020,
			fl_int | fl_br | fl_ds | fl_pred);
		issue(enc_i(OP_REGIMM, 4, RI_BGEZAL, 16'h0020), 1'b1, '0);
		expect_uop(BAL, 0, 1'b1, 31, 1'b0, 31, 1'b1, 16'h0020, fl_int | fl_br | fl_ds | fl_pred);
		issue(enc_i(OP_REGIMM, 0, RI_BGEZAL, 16'h0020), 1'b1, '0);
		expect_uop(II, 4, 1'b1, 0, 1'b0, 0, 1'b0, 16'h0030, fl_int | fl_br | fl_ds);
		issue(enc_i(OP_REGIMM, 4, 5'd9, 16'h0030), 1'b0, '0);
		expect_uop(JAL, 0, 1'b0, 0, 1'b0, 31, 1'b1, 16'hcdef, fl_int | fl_br | fl_ds | fl_pred);
		e_jmp = 16'h03ab; // target bits 25..16
		issue({OP_JAL, 26'h3abcdef}, 1'b0, '0);
	endtask

	task automatic test_mem();
		expect_uop(LW, 2, 1'b1, 0, 1'b0, 3, 1'b1, 16'h0004, fl_mem);
		issue(enc_i(OP_LW, 2, 3, 16'h0004), 1'b0, '0);
		expect_uop(LBU, 2, 1'b1, 0, 1'b0, 5, 1'b1, 16'h0001, fl_mem);
		issue(enc_i(OP_LBU, 2, 5, 16'h0001), 1'b0, '0);
		expect_uop(LW, 2, 1'b1, 0, 1'b0, 6, 1'b1, 16'h0008, fl_mem);
		issue(enc_i(OP_LL, 2, 6, 16'h0008), 1'b0, '0);
		expect_uop(LWL, 2, 1'b1, 3, 1'b1, 3, 1'b1, 16'h0003, fl_mem);
		issue(enc_i(OP_LWL, 2, 3, 16'h0003), 1'b0, '0);
		expect_uop(SW, 2, 1'b1, 3, 1'b1, 0, 1'b0, 16'h0008, fl_mem | fl_st);
		issue(enc_i(OP_SW, 2, 3, 16'h0008), 1'b0, '0);
		expect_uop(SH, 2, 1'b1, 7, 1'b1, 0, 1'b0, 16'h000a, fl_mem | fl_st);
		issue(enc_i(OP_SH, 2, 7, 16'h000a), 1'b0, '0);
		expect_uop(NOP, 0, 1'b0, 0, 1'b0, 0, 1'b0, 16'h0, fl_int);
		issue(enc_i(OP_PREF, 2, 1, 16'h0010), 1'b0, '0);
	endtask

	task automatic test_illegal();
		expect_uop(II, 0, 1'b0, 0, 1'b0, 0, 1'b0, 16'h0, 9'h0);
		issue(enc_i(6'd16, 0, 4, 16'h6000), 1'b0, '0); // cop0
		issue(enc_i(6'd17, 0, 4, 16'h0800), 1'b0, '0); // cop1
		issue(enc_i(6'd63, 5, 6, 16'h1111), 1'b0, '0);
		issue(enc_r(0, 0, 0, 0, 6'd13), 1'b0, '0); // break
	endtask

	task automatic test_stream();
		logic [31:0] words [$];
		logic [`DEC_ADDR_W-1:0] pcs [$];
		logic [31:0] w;
		logic [`DEC_ADDR_W-1:0] p;
		for (int i = 0; i <= 64; i++)
		begin
			@(posedge clk);
			if (i < 64)
			begin
				rng = xorshift32(rng);
				w = enc_i(OP_ADDIU, rng[25:21], rng[20:16], rng[15:0]);
				insn_valid <= 1'b1;
				insn <= w;
				pc <= next_pc;
				insn_pred <= 1'b0;
				pht_idx <= next_pc[`DEC_PHT_W+1:2];
				insn_pred_target <= '0;
				words.push_back(w);
				pcs.push_back(next_pc);
				next_pc += 4;
			end
			else
				insn_valid <= 1'b0;
			@(negedge clk);
			if (i > 0)
			begin
				check("uop_valid", uop_valid, 1);
				w = words.pop_front();
				p = pcs.pop_front();
				expect_addiu(w);
				compare_uop(p);
			end
		end
		@(negedge clk);
		check("uop_valid", uop_valid, 0); // gap follows the stream
	endtask

	always @(decode_stage_inst.decode_properties_inst.assert_errors)
	begin
		if (decode_stage_inst.decode_properties_inst.assert_errors != 0)
			abort_run("a bound assertion on decode_stage failed");
	end

	initial
	begin
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		rng = 32'h4bee;
		next_pc = 32'h0040_0000;
		test_reset_state();
		test_rtype();
		test_imm_alu();
		test_branch();
		test_mem();
		test_illegal();
		test_stream();
		@(negedge clk);
		if (decode_stage_inst.decode_properties_inst.assert_errors != 0)
			abort_run("a bound assertion on decode_stage failed");
		else
		begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/decode_pkg.sv
logic/decode_rtype.sv
logic/decode_imm_alu.sv
logic/decode_branch.sv
logic/decode_mem.sv
logic/decode_stage.sv
tb/decode_clock_gen.sv
tb/decode_properties.sv
tb/decode_tb.sv
